//--- regex_pkg.sv
package regex_pkg;

  // Stream and category dimensions
  localparam int NUM_STREAMS    = 64;
  localparam int NUM_CATEGORIES = 2;

  // Category slots in the enable mask and the fired vector
  localparam int CAT_DHCP   = 0;
  localparam int CAT_FINGER = 1;

  // Widest pattern a matcher can hold, in bytes
  localparam int PAT_LEN_MAX = 8;

  // First pattern byte sits in the low byte, unused bytes at the top are zero
  localparam logic [PAT_LEN_MAX*8-1:0] PAT_DHCP   = 64'h0000_0000_7063_6864;
  localparam logic [PAT_LEN_MAX*8-1:0] PAT_FINGER = 64'h0000_7265_676e_6966;
  localparam int PAT_DHCP_LEN   = 4;
  localparam int PAT_FINGER_LEN = 6;

  // Byte path delay so the first byte follows the restored state
  localparam int CHAR_DELAY = 2;
  // End of packet delay so the match flag has settled
  localparam int EOP_DELAY  = 6;

  // Payload byte
  typedef logic [7:0] char_t;

  // Pattern bytes matched so far
  typedef logic [10:0] dfa_state_t;

  // Stream number
  typedef logic [$clog2(NUM_STREAMS)-1:0] stream_id_t;

  // Packets with at least one match, wraps
  typedef logic [15:0] count_t;

  // One bit per category
  typedef logic [NUM_CATEGORIES-1:0] cat_mask_t;

  // Byte beat on the payload path
  typedef struct packed {
    char_t char;
    logic  vld;
  } char_beat_t;

  // Packet framing in the sequencer
  typedef enum logic {
    SEQ_IDLE,
    SEQ_PKT
  } seq_state_e;

endpackage

//--- literal_dfa.sv
module literal_dfa #(
  parameter logic [regex_pkg::PAT_LEN_MAX*8-1:0] PATTERN = regex_pkg::PAT_DHCP,
  parameter int PAT_LEN = regex_pkg::PAT_DHCP_LEN
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  regex_pkg::char_t       char_in,
  input  logic                   char_in_vld,
  input  regex_pkg::dfa_state_t  state_in,
  input  logic                   state_in_vld,
  output regex_pkg::dfa_state_t  state_out,
  output logic                   accept_out
);

  // Current match depth
  regex_pkg::dfa_state_t state_q;

  // Byte position of the next expected pattern byte
  logic [$clog2(regex_pkg::PAT_LEN_MAX)-1:0] pat_idx;

  regex_pkg::char_t next_byte;
  regex_pkg::char_t first_byte;
  regex_pkg::dfa_state_t state_inc;

  // State never exceeds PAT_LEN-1 between bytes, so low bits suffice
  assign pat_idx = state_q[$clog2(regex_pkg::PAT_LEN_MAX)-1:0];

  assign next_byte  = PATTERN[pat_idx*8 +: 8];
  assign first_byte = PATTERN[7:0];
  assign state_inc  = state_q + regex_pkg::dfa_state_t'(1);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q    <= '0;
      accept_out <= 1'b0;
    end
    else
    begin
      // Accept is a one cycle pulse
      accept_out <= 1'b0;

      // Restored state wins over any byte
      if (state_in_vld)
      begin
        state_q <= state_in;
      end
      else if (char_in_vld)
      begin
        if (char_in == next_byte)
        begin
          // Whole pattern seen, report and start over
          if (state_inc == regex_pkg::dfa_state_t'(PAT_LEN))
          begin
            state_q    <= '0;
            accept_out <= 1'b1;
          end
          else
          begin
            state_q <= state_inc;
          end
        end
        // Mismatch may still start a fresh match
        else if (char_in == first_byte)
        begin
          state_q <= regex_pkg::dfa_state_t'(1);
        end
        else
        begin
          state_q <= '0;
        end
      end
    end
  end

  assign state_out = state_q;

endmodule

//--- category_matcher.sv
module category_matcher #(
  parameter logic [regex_pkg::PAT_LEN_MAX*8-1:0] PATTERN = regex_pkg::PAT_DHCP,
  parameter int PAT_LEN = regex_pkg::PAT_DHCP_LEN
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  regex_pkg::char_beat_t   beat,
  input  logic                    load_state,
  input  logic                    new_stream_id,
  input  regex_pkg::stream_id_t   stream_id,
  input  logic                    eop,
  input  logic                    enable,
  output regex_pkg::count_t       count,
  output logic                    fired
);

  // Saved DFA state per stream
  regex_pkg::dfa_state_t state_mem [regex_pkg::NUM_STREAMS];

  // Restored state, one cycle after load
  regex_pkg::dfa_state_t state_in;
  logic                  state_in_vld;

  // Registered DFA inputs
  regex_pkg::char_t      char_in_r;
  logic                  char_in_vld_r;
  regex_pkg::dfa_state_t state_in_r;
  logic                  state_in_vld_r;

  // Raw and registered DFA outputs
  regex_pkg::dfa_state_t state_out;
  logic                  accept_out;
  regex_pkg::dfa_state_t state_out_r;
  logic                  accept_out_r;

  // Packet saw at least one match
  logic match_flag;

  // Restore the stream state, new streams start from zero
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_in_vld <= 1'b0;
    end
    else
    begin
      state_in_vld <= load_state;
    end
    if (load_state)
    begin
      state_in <= new_stream_id ? '0 : state_mem[stream_id];
    end
  end

  // Register everything at the DFA boundary
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      char_in_vld_r  <= 1'b0;
      state_in_vld_r <= 1'b0;
      accept_out_r   <= 1'b0;
    end
    else
    begin
      char_in_vld_r  <= beat.vld;
      state_in_vld_r <= state_in_vld;
      accept_out_r   <= accept_out;
    end
    char_in_r   <= beat.char;
    state_in_r  <= state_in;
    state_out_r <= state_out;
  end

  // Match flag and end of packet bookkeeping
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count      <= '0;
      match_flag <= 1'b0;
    end
    else
    begin
      if (load_state)
      begin
        match_flag <= 1'b0;
      end
      // Any accept in the packet sets it
      if (accept_out_r)
      begin
        match_flag <= 1'b1;
      end
      if (eop)
      begin
        if (enable)
        begin
          count                <= count + regex_pkg::count_t'(match_flag);
          state_mem[stream_id] <= state_out_r;
        end
        else
        begin
          // Saved state untouched, the flag is dropped
          match_flag <= 1'b0;
        end
      end
    end
  end

  assign fired = match_flag;

  literal_dfa #(
    .PATTERN (PATTERN),
    .PAT_LEN (PAT_LEN)
  ) i_dfa (
    .clk          (clk),
    .rst_n        (rst_n),
    .char_in      (char_in_r),
    .char_in_vld  (char_in_vld_r),
    .state_in     (state_in_r),
    .state_in_vld (state_in_vld_r),
    .state_out    (state_out),
    .accept_out   (accept_out)
  );

endmodule

//--- stream_sequencer.sv
module stream_sequencer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    sop,
  input  regex_pkg::stream_id_t   in_stream_id,
  input  regex_pkg::char_beat_t   beat,
  input  logic                    eop,
  input  logic                    cfg_we,
  input  regex_pkg::stream_id_t   cfg_stream,
  input  regex_pkg::cat_mask_t    cfg_enable,
  output logic                    load_state,
  output logic                    new_stream_id,
  output regex_pkg::stream_id_t   stream_id,
  output regex_pkg::char_beat_t   beat_d,
  output logic                    eop_d,
  output regex_pkg::cat_mask_t    enable
);

  // Packet framing state
  regex_pkg::seq_state_e state_q;

  // Streams that have loaded at least once
  logic [regex_pkg::NUM_STREAMS-1:0] seen_q;

  // Per stream category enables
  regex_pkg::cat_mask_t enable_tbl [regex_pkg::NUM_STREAMS];

  // Alignment pipes
  regex_pkg::char_beat_t beat_pipe [regex_pkg::CHAR_DELAY];
  logic [regex_pkg::EOP_DELAY-1:0] eop_pipe;

  // Framed inputs
  logic                  pkt_start;
  logic                  in_pkt;
  regex_pkg::char_beat_t beat_in;

  // Sop during a packet is dropped
  assign pkt_start = sop && (state_q == regex_pkg::SEQ_IDLE);
  assign in_pkt    = (state_q == regex_pkg::SEQ_PKT);

  // Bytes outside a packet never reach the matchers
  assign beat_in.char = beat.char;
  assign beat_in.vld  = beat.vld && in_pkt;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q <= regex_pkg::SEQ_IDLE;
    end
    else
    begin
      case (state_q)
        regex_pkg::SEQ_IDLE:
        begin
          if (sop)
          begin
            state_q <= regex_pkg::SEQ_PKT;
          end
        end
        regex_pkg::SEQ_PKT:
        begin
          if (eop)
          begin
            state_q <= regex_pkg::SEQ_IDLE;
          end
        end
        default:
        begin
          state_q <= regex_pkg::SEQ_IDLE;
        end
      endcase
    end
  end

  // Load pulse, stream lookup and table updates
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      load_state    <= 1'b0;
      new_stream_id <= 1'b0;
      stream_id     <= '0;
      enable        <= '0;
      seen_q        <= '0;
      for (int i = 0; i < regex_pkg::NUM_STREAMS; i++)
      begin
        enable_tbl[i] <= '0;
      end
    end
    else
    begin
      load_state <= pkt_start;
      if (pkt_start)
      begin
        new_stream_id <= !seen_q[in_stream_id];
        stream_id     <= in_stream_id;
        // Mask held for the whole packet
        enable        <= enable_tbl[in_stream_id];
      end
      // Stream counts as seen once it has loaded
      if (load_state)
      begin
        seen_q[stream_id] <= 1'b1;
      end
      if (cfg_we)
      begin
        enable_tbl[cfg_stream] <= cfg_enable;
      end
    end
  end

  // Byte and eop delay lines
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      eop_pipe <= '0;
      for (int i = 0; i < regex_pkg::CHAR_DELAY; i++)
      begin
        beat_pipe[i].vld <= 1'b0;
      end
    end
    else
    begin
      eop_pipe     <= {eop_pipe[regex_pkg::EOP_DELAY-2:0], eop && in_pkt};
      beat_pipe[0] <= beat_in;
      for (int i = 1; i < regex_pkg::CHAR_DELAY; i++)
      begin
        beat_pipe[i] <= beat_pipe[i-1];
      end
    end
  end

  assign beat_d = beat_pipe[regex_pkg::CHAR_DELAY-1];
  assign eop_d  = eop_pipe[regex_pkg::EOP_DELAY-1];

endmodule

//--- regex_top.sv
module regex_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    sop,
  input  regex_pkg::stream_id_t   in_stream_id,
  input  regex_pkg::char_beat_t   beat,
  input  logic                    eop,
  input  logic                    cfg_we,
  input  regex_pkg::stream_id_t   cfg_stream,
  input  regex_pkg::cat_mask_t    cfg_enable,
  output regex_pkg::count_t       count_dhcp,
  output regex_pkg::count_t       count_finger,
  output regex_pkg::cat_mask_t    fired
);

  // Shared matcher controls
  logic                  load_state;
  logic                  new_stream_id;
  regex_pkg::stream_id_t stream_id;
  regex_pkg::char_beat_t beat_d;
  logic                  eop_d;
  regex_pkg::cat_mask_t  enable;

  stream_sequencer i_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .sop           (sop),
    .in_stream_id  (in_stream_id),
    .beat          (beat),
    .eop           (eop),
    .cfg_we        (cfg_we),
    .cfg_stream    (cfg_stream),
    .cfg_enable    (cfg_enable),
    .load_state    (load_state),
    .new_stream_id (new_stream_id),
    .stream_id     (stream_id),
    .beat_d        (beat_d),
    .eop_d         (eop_d),
    .enable        (enable)
  );

  // "dhcp" category
  category_matcher #(
    .PATTERN (regex_pkg::PAT_DHCP),
    .PAT_LEN (regex_pkg::PAT_DHCP_LEN)
  ) i_dhcp (
    .clk           (clk),
    .rst_n         (rst_n),
    .beat          (beat_d),
    .load_state    (load_state),
    .new_stream_id (new_stream_id),
    .stream_id     (stream_id),
    .eop           (eop_d),
    .enable        (enable[regex_pkg::CAT_DHCP]),
    .count         (count_dhcp),
    .fired         (fired[regex_pkg::CAT_DHCP])
  );

  // "finger" category
  category_matcher #(
    .PATTERN (regex_pkg::PAT_FINGER),
    .PAT_LEN (regex_pkg::PAT_FINGER_LEN)
  ) i_finger (
    .clk           (clk),
    .rst_n         (rst_n),
    .beat          (beat_d),
    .load_state    (load_state),
    .new_stream_id (new_stream_id),
    .stream_id     (stream_id),
    .eop           (eop_d),
    .enable        (enable[regex_pkg::CAT_FINGER]),
    .count         (count_finger),
    .fired         (fired[regex_pkg::CAT_FINGER])
  );

endmodule

//--- regex_checker.sv
module regex_checker (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sop,
  input  regex_pkg::stream_id_t  in_stream_id,
  input  regex_pkg::char_beat_t  beat,
  input  logic                   eop,
  input  logic                   cfg_we,
  input  regex_pkg::stream_id_t  cfg_stream,
  input  regex_pkg::cat_mask_t   cfg_enable,
  input  regex_pkg::count_t      count_dhcp,
  input  regex_pkg::count_t      count_finger,
  input  regex_pkg::cat_mask_t   fired,
  output int                     pass_cnt,
  output int                     fail_cnt
);

  // Model of the enable table and per stream history
  regex_pkg::cat_mask_t en_tbl [64];
  bit                   seen [64];
  int                   saved_depth [64][2];

  // Packet in flight
  bit                    in_pkt;
  regex_pkg::stream_id_t cur_stream;
  regex_pkg::cat_mask_t  cur_en;
  int                    cur_depth [2];
  bit                    cur_hit [2];

  // Expected outputs after the last packet end
  regex_pkg::count_t    exp_count [2];
  regex_pkg::cat_mask_t exp_fired;

  // Countdowns to the two check points
  int chk_cnt;
  int clr_cnt;
  int pkt_num;
  bit pkt_err;

  // Category 0 is dhcp, 1 is finger, same order as the fired bits
  function automatic string pat_str(input int cat);
    return (cat == 0) ? "dhcp" : "finger";
  endfunction

  // Literal match depth after one byte
  function automatic int next_depth(input int cat, input int depth, input logic [7:0] ch,
                                    output bit hit);
    string pat;
    pat = pat_str(cat);
    hit = 1'b0;
    if (ch == pat.getc(depth))
    begin
      if (depth + 1 == pat.len())
      begin
        hit = 1'b1;
        return 0;
      end
      return depth + 1;
    end
    // A mismatch can still open a new match
    if (ch == pat.getc(0))
    begin
      return 1;
    end
    return 0;
  endfunction

  // Track inputs where they were driven, on the rising edge
  always @(posedge clk)
  begin
    bit hit;
    if (!rst_n)
    begin
      for (int i = 0; i < 64; i++)
      begin
        en_tbl[i]         = '0;
        seen[i]           = 1'b0;
        saved_depth[i][0] = 0;
        saved_depth[i][1] = 0;
      end
      in_pkt       = 1'b0;
      exp_count[0] = '0;
      exp_count[1] = '0;
      exp_fired    = '0;
      chk_cnt      = 0;
      clr_cnt      = 0;
    end
    else
    begin
      if (chk_cnt > 0)
        chk_cnt--;
      if (clr_cnt > 0)
        clr_cnt--;
      if (sop && !in_pkt)
      begin
        in_pkt     = 1'b1;
        cur_stream = in_stream_id;
        cur_en     = en_tbl[in_stream_id];
        // Unseen streams start clean
        for (int c = 0; c < 2; c++)
        begin
          cur_depth[c] = seen[in_stream_id] ? saved_depth[in_stream_id][c] : 0;
          cur_hit[c]   = 1'b0;
        end
        seen[in_stream_id] = 1'b1;
        clr_cnt = 2;
      end
      else if (in_pkt && beat.vld)
      begin
        for (int c = 0; c < 2; c++)
        begin
          cur_depth[c] = next_depth(c, cur_depth[c], beat.char, hit);
          if (hit)
            cur_hit[c] = 1'b1;
        end
      end
      else if (in_pkt && eop)
      begin
        for (int c = 0; c < 2; c++)
        begin
          if (cur_en[c])
          begin
            exp_count[c] = exp_count[c] + regex_pkg::count_t'(cur_hit[c]);
            saved_depth[cur_stream][c] = cur_depth[c];
            exp_fired[c] = cur_hit[c];
          end
          else
          begin
            // Disabled category keeps its old saved depth
            exp_fired[c] = 1'b0;
          end
        end
        in_pkt  = 1'b0;
        chk_cnt = 9;
      end
      // Table write lands after any lookup in the same cycle
      if (cfg_we)
        en_tbl[cfg_stream] = cfg_enable;
    end
  end

  // Compare DUT outputs on the falling edge, away from updates
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      pass_cnt = 0;
      fail_cnt = 0;
      pkt_num  = 0;
      pkt_err  = 1'b0;
    end
    else
    begin
      // Flag must be cleared by the load of a new packet
      if (clr_cnt == 1 && fired !== 2'b00)
      begin
        $display("Error fired after load: got %h expected %h", fired, 2'b00);
        pkt_err = 1'b1;
      end
      // Eight cycles after eop
      if (chk_cnt == 1)
      begin
        if (count_dhcp !== exp_count[0])
        begin
          $display("Error count_dhcp: got %h expected %h", count_dhcp, exp_count[0]);
          pkt_err = 1'b1;
        end
        if (count_finger !== exp_count[1])
        begin
          $display("Error count_finger: got %h expected %h", count_finger, exp_count[1]);
          pkt_err = 1'b1;
        end
        if (fired !== exp_fired)
        begin
          $display("Error fired: got %h expected %h", fired, exp_fired);
          pkt_err = 1'b1;
        end
        if (pkt_err)
        begin
          fail_cnt++;
          $display("packet %0d stream %0d: mismatch", pkt_num, cur_stream);
        end
        else
        begin
          pass_cnt++;
          $display("packet %0d stream %0d: ok, count_dhcp %h count_finger %h fired %h",
                   pkt_num, cur_stream, count_dhcp, count_finger, fired);
        end
        pkt_num++;
        pkt_err = 1'b0;
      end
    end
  end

endmodule

//--- regex_tb.sv
module regex_tb;

  localparam int NUM_ROWS     = 16;
  localparam int MAX_BYTES    = 12;
  localparam int GAP_CYCLES   = 10;
  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 5;
  // Config, sop, bytes, eop and idle gap
  localparam int ROW_CYCLES   = 3 + MAX_BYTES + GAP_CYCLES;
  localparam int TIMEOUT      = (RESET_CYCLES + NUM_ROWS * ROW_CYCLES + 50) * CLK_PERIOD;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  sop;
  regex_pkg::stream_id_t in_stream_id;
  regex_pkg::char_beat_t beat;
  logic                  eop;
  logic                  cfg_we;
  regex_pkg::stream_id_t cfg_stream;
  regex_pkg::cat_mask_t  cfg_enable;
  regex_pkg::count_t     count_dhcp;
  regex_pkg::count_t     count_finger;
  regex_pkg::cat_mask_t  fired;
  int                    pass_cnt;
  int                    fail_cnt;

  integer seed = 98;

  // Packet table, '.' marks a random filler byte
  // Mask bit 0 enables dhcp, bit 1 enables finger
  regex_pkg::stream_id_t row_stream [NUM_ROWS] = '{
    6'd1, 6'd1, 6'd2, 6'd2, 6'd3, 6'd5, 6'd3, 6'd7,
    6'd7, 6'd7, 6'd4, 6'd6, 6'd63, 6'd1, 6'd0, 6'd8
  };
  string row_payload [NUM_ROWS] = '{
    "..dhcp..", "dhcp.dhcp", "....fin", "ger.....",
    "....dh", "cp....", "cp..", ".fingerdh",
    "cp..dhcp", "cp....", "......", "dhcpfinger",
    "fingefinger", "hcp", "dhdhcp......", "finger.dhcp"
  };
  int row_len [NUM_ROWS] = '{
    8, 9, 7, 8, 6, 6, 4, 9, 8, 6, 6, 10, 11, 3, 12, 11
  };
  regex_pkg::cat_mask_t row_mask [NUM_ROWS] = '{
    2'b11, 2'b11, 2'b11, 2'b11, 2'b11, 2'b11, 2'b11, 2'b11,
    2'b10, 2'b11, 2'b11, 2'b11, 2'b11, 2'b11, 2'b11, 2'b01
  };

  always #(CLK_PERIOD / 2) clk = ~clk;

  regex_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .sop          (sop),
    .in_stream_id (in_stream_id),
    .beat         (beat),
    .eop          (eop),
    .cfg_we       (cfg_we),
    .cfg_stream   (cfg_stream),
    .cfg_enable   (cfg_enable),
    .count_dhcp   (count_dhcp),
    .count_finger (count_finger),
    .fired        (fired)
  );

  regex_checker i_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .sop          (sop),
    .in_stream_id (in_stream_id),
    .beat         (beat),
    .eop          (eop),
    .cfg_we       (cfg_we),
    .cfg_stream   (cfg_stream),
    .cfg_enable   (cfg_enable),
    .count_dhcp   (count_dhcp),
    .count_finger (count_finger),
    .fired        (fired),
    .pass_cnt     (pass_cnt),
    .fail_cnt     (fail_cnt)
  );

  // Letters of either pattern
  function automatic bit is_pattern_letter(input logic [7:0] ch);
    string letters;
    letters = "dhcpfinger";
    for (int i = 0; i < letters.len(); i++)
    begin
      if (ch == letters.getc(i))
        return 1'b1;
    end
    return 1'b0;
  endfunction

  // Filler never starts or extends a match
  task automatic pick_filler(output logic [7:0] ch);
    ch = 8'($random(seed));
    while (is_pattern_letter(ch))
      ch = 8'($random(seed));
  endtask

  // Enable write, then one packet, then the idle gap
  task automatic send_row(input int r);
    logic [7:0] ch;
    string      payload;
    payload = row_payload[r];
    @(negedge clk);
    cfg_we     = 1'b1;
    cfg_stream = row_stream[r];
    cfg_enable = row_mask[r];
    @(negedge clk);
    cfg_we       = 1'b0;
    sop          = 1'b1;
    in_stream_id = row_stream[r];
    for (int i = 0; i < row_len[r]; i++)
    begin
      @(negedge clk);
      sop = 1'b0;
      ch  = payload.getc(i);
      if (ch == ".")
        pick_filler(ch);
      beat.char = ch;
      beat.vld  = 1'b1;
    end
    // Eop carries no byte
    @(negedge clk);
    sop       = 1'b0;
    beat.vld  = 1'b0;
    beat.char = '0;
    eop       = 1'b1;
    @(negedge clk);
    eop = 1'b0;
    repeat (GAP_CYCLES - 1) @(negedge clk);
  endtask

  initial
  begin
    rst_n        = 1'b0;
    sop          = 1'b0;
    in_stream_id = '0;
    beat         = '0;
    eop          = 1'b0;
    cfg_we       = 1'b0;
    cfg_stream   = '0;
    cfg_enable   = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    for (int r = 0; r < NUM_ROWS; r++)
      send_row(r);
    // Every packet must have been checked
    wait (pass_cnt + fail_cnt == NUM_ROWS);
    @(negedge clk);
    $display("Packets checked: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // Watchdog sized from the table length
  initial
  begin
    #(TIMEOUT);
    $display("Timeout: the packet table did not finish within %0d time units", TIMEOUT);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- vlog.f
regex_pkg.sv
literal_dfa.sv
category_matcher.sv
stream_sequencer.sv
regex_top.sv
regex_checker.sv
regex_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := regex_tb
FILELIST  := vlog.f
VFLAGS    := --binary --timing -j 0
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "Simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
